/* Bender.yml */
package:
  name: jtag_tap

sources:
  - include_dirs:
      - design
    files:
      - design/tap_state_pkg.sv
      - design/tap_instr_pkg.sv
      - design/tap_fsm_ctrl.sv
      - design/tap_ir_reg.sv
      - design/tap_dr_bank.sv
      - design/tap_tdo_out.sv
      - design/tap_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/tap_assertions.sv
      - verif/tap_tb.sv

/* design/tap_dr_bank.sv */
`timescale 1ns/10ps
`include "tap_params.svh"

module tap_dr_bank (
    input  logic                        tapc_tck,
    input  logic                        tapc_trst_n,
    input  logic                        sync_rst_n_i,
    input  tap_state_pkg::tap_ctrl_t    ctrl_i,
    input  tap_instr_pkg::tap_dr_sel_e  dr_sel_i,
    input  logic                        tdi_i,
    // Device id from fuses
    input  logic [`TAP_IDCODE_W-1:0]    idcode_i,
    // Serial out of the selected register
    output logic                        dr_tdo_o
);

    import tap_instr_pkg::*;

    logic [`TAP_BYPASS_W-1:0] bypass_q;
    logic [`TAP_IDCODE_W-1:0] idcode_q;
    logic [`TAP_BLD_ID_W-1:0] bld_id_q;

    // One-hot register select
    logic bypass_sel;
    logic idcode_sel;
    logic bld_id_sel;

    assign bypass_sel = (dr_sel_i == SEL_BYPASS);
    assign idcode_sel = (dr_sel_i == SEL_IDCODE);
    assign bld_id_sel = (dr_sel_i == SEL_BLD_ID);

    // --------------------------------------------------
    // Capture and shift on rising TCK
    // --------------------------------------------------
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            bypass_q <= '0;
            idcode_q <= '0;
            bld_id_q <= '0;
        end else if (!sync_rst_n_i) begin
            bypass_q <= '0;
            idcode_q <= '0;
            bld_id_q <= '0;
        end else if (ctrl_i.dr_capture) begin
            // Parallel load of selected register only
            if (bypass_sel) begin
                bypass_q <= '0;
            end
            if (idcode_sel) begin
                idcode_q <= idcode_i;
            end
            if (bld_id_sel) begin
                bld_id_q <= `TAP_BLD_ID_VALUE;
            end
        end else if (ctrl_i.dr_shift) begin
            // TDI enters at MSB
            if (bypass_sel) begin
                bypass_q <= tdi_i;
            end
            if (idcode_sel) begin
                idcode_q <= {tdi_i, idcode_q[`TAP_IDCODE_W-1:1]};
            end
            if (bld_id_sel) begin
                bld_id_q <= {tdi_i, bld_id_q[`TAP_BLD_ID_W-1:1]};
            end
        end
    end

    // --------------------------------------------------
    // Serial output mux
    // --------------------------------------------------
    always_comb begin
        case (dr_sel_i)
            SEL_IDCODE : dr_tdo_o = idcode_q[0];
            SEL_BLD_ID : dr_tdo_o = bld_id_q[0];
            // Chain data is muxed in the TDO stage
            default    : dr_tdo_o = bypass_q[0];
        endcase
    end

endmodule

/* design/tap_fsm_ctrl.sv */
`timescale 1ns/10ps

module tap_fsm_ctrl (
    // JTAG clock and reset
    input  logic                    tapc_tck,
    input  logic                    tapc_trst_n,
    // Mode select, sampled on rising TCK
    input  logic                    tms_i,
    // Strobes to the datapath
    output tap_state_pkg::tap_ctrl_t ctrl_o,
    output logic                    dr_update_o,
    // Reset while in Test-Logic-Reset
    output logic                    sync_rst_n_o
);

    import tap_state_pkg::*;

    tap_state_e state_q;
    tap_state_e state_d;

    // Registered DR phase strobes
    logic dr_capture_q;
    logic dr_shift_q;
    logic dr_update_q;

    logic sync_rst_n_q;

    // --------------------------------------------------
    // State register
    // --------------------------------------------------
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            state_q <= TAP_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state from TMS
    always_comb begin
        case (state_q)
            TAP_RESET      : state_d = tms_i ? TAP_RESET     : TAP_IDLE;
            TAP_IDLE       : state_d = tms_i ? TAP_DR_SELECT : TAP_IDLE;
            TAP_DR_SELECT  : state_d = tms_i ? TAP_IR_SELECT : TAP_DR_CAPTURE;
            TAP_DR_CAPTURE : state_d = tms_i ? TAP_DR_EXIT1  : TAP_DR_SHIFT;
            TAP_DR_SHIFT   : state_d = tms_i ? TAP_DR_EXIT1  : TAP_DR_SHIFT;
            TAP_DR_EXIT1   : state_d = tms_i ? TAP_DR_UPDATE : TAP_DR_PAUSE;
            TAP_DR_PAUSE   : state_d = tms_i ? TAP_DR_EXIT2  : TAP_DR_PAUSE;
            TAP_DR_EXIT2   : state_d = tms_i ? TAP_DR_UPDATE : TAP_DR_SHIFT;
            TAP_DR_UPDATE  : state_d = tms_i ? TAP_DR_SELECT : TAP_IDLE;
            TAP_IR_SELECT  : state_d = tms_i ? TAP_RESET     : TAP_IR_CAPTURE;
            TAP_IR_CAPTURE : state_d = tms_i ? TAP_IR_EXIT1  : TAP_IR_SHIFT;
            TAP_IR_SHIFT   : state_d = tms_i ? TAP_IR_EXIT1  : TAP_IR_SHIFT;
            TAP_IR_EXIT1   : state_d = tms_i ? TAP_IR_UPDATE : TAP_IR_PAUSE;
            TAP_IR_PAUSE   : state_d = tms_i ? TAP_IR_EXIT2  : TAP_IR_PAUSE;
            TAP_IR_EXIT2   : state_d = tms_i ? TAP_IR_UPDATE : TAP_IR_SHIFT;
            TAP_IR_UPDATE  : state_d = tms_i ? TAP_DR_SELECT : TAP_IDLE;
            // Unreachable, hold state
            default        : state_d = state_q;
        endcase
    end

    // --------------------------------------------------
    // Synchronous reset on falling TCK
    // --------------------------------------------------
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            sync_rst_n_q <= 1'b0;
        end else begin
            sync_rst_n_q <= (state_q != TAP_RESET);
        end
    end

    // --------------------------------------------------
    // DR strobes, high exactly while in that state
    // --------------------------------------------------
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            dr_capture_q <= 1'b0;
            dr_shift_q   <= 1'b0;
            dr_update_q  <= 1'b0;
        end else if (!sync_rst_n_q) begin
            dr_capture_q <= 1'b0;
            dr_shift_q   <= 1'b0;
            dr_update_q  <= 1'b0;
        end else begin
            dr_capture_q <= (state_d == TAP_DR_CAPTURE);
            dr_shift_q   <= (state_d == TAP_DR_SHIFT);
            dr_update_q  <= (state_d == TAP_DR_UPDATE);
        end
    end

    // IR strobes straight from current state
    assign ctrl_o.ir_capture = (state_q == TAP_IR_CAPTURE);
    assign ctrl_o.ir_shift   = (state_q == TAP_IR_SHIFT);
    assign ctrl_o.ir_update  = (state_q == TAP_IR_UPDATE);
    assign ctrl_o.dr_capture = dr_capture_q;
    assign ctrl_o.dr_shift   = dr_shift_q;

    assign dr_update_o  = dr_update_q;
    assign sync_rst_n_o = sync_rst_n_q;

endmodule

/* design/tap_instr_pkg.sv */
`include "tap_params.svh"

package tap_instr_pkg;

    // Supported instructions
    typedef enum logic [`TAP_IR_W-1:0] {
        OP_IDCODE = `TAP_OP_IDCODE,
        OP_BLD_ID = `TAP_OP_BLD_ID,
        OP_SCU    = `TAP_OP_SCU,
        OP_DTMCS  = `TAP_OP_DTMCS,
        OP_DMI    = `TAP_OP_DMI,
        OP_BYPASS = `TAP_OP_BYPASS
    } tap_opcode_e;

    // Register that answers the data scan
    typedef enum logic [1:0] {
        SEL_BYPASS = 2'd0,
        SEL_IDCODE = 2'd1,
        SEL_BLD_ID = 2'd2,
        SEL_CHAIN  = 2'd3
    } tap_dr_sel_e;

    // Outgoing DMI/SCU scan-chain port
    typedef struct packed {
        logic                    dmi_sel;
        logic                    scu_sel;
        logic [`TAP_CH_ID_W-1:0] ch_id;
        logic                    capture;
        logic                    shift;
        logic                    update;
        logic                    tdi;
    } tap_chain_t;

endpackage

/* design/tap_ir_reg.sv */
`timescale 1ns/10ps
`include "tap_params.svh"

module tap_ir_reg (
    input  logic                        tapc_tck,
    input  logic                        tapc_trst_n,
    input  logic                        sync_rst_n_i,
    input  tap_state_pkg::tap_ctrl_t    ctrl_i,
    input  logic                        tdi_i,
    // Serial out of the shift stage
    output logic                        ir_lsb_o,
    // Decoded instruction
    output tap_instr_pkg::tap_dr_sel_e  dr_sel_o,
    output logic                        dmi_sel_o,
    output logic                        scu_sel_o,
    output logic [`TAP_CH_ID_W-1:0]     ch_id_o
);

    import tap_instr_pkg::*;

    logic [`TAP_IR_W-1:0] ir_shift_q;
    logic [`TAP_IR_W-1:0] ir_q;

    // --------------------------------------------------
    // Shift stage on rising TCK
    // --------------------------------------------------
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            ir_shift_q <= '0;
        end else if (!sync_rst_n_i) begin
            ir_shift_q <= '0;
        end else if (ctrl_i.ir_capture) begin
            // Mandatory 01 pattern in the low bits
            ir_shift_q <= `TAP_IR_W'(1);
        end else if (ctrl_i.ir_shift) begin
            ir_shift_q <= {tdi_i, ir_shift_q[`TAP_IR_W-1:1]};
        end
    end

    assign ir_lsb_o = ir_shift_q[0];

    // Update stage on falling TCK
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            ir_q <= OP_IDCODE;
        end else if (!sync_rst_n_i) begin
            ir_q <= OP_IDCODE;
        end else if (ctrl_i.ir_update) begin
            ir_q <= ir_shift_q;
        end
    end

    // --------------------------------------------------
    // Opcode decode
    // --------------------------------------------------
    always_comb begin
        dr_sel_o  = SEL_BYPASS;
        dmi_sel_o = 1'b0;
        scu_sel_o = 1'b0;
        ch_id_o   = '0;
        case (ir_q)
            OP_IDCODE : dr_sel_o = SEL_IDCODE;
            OP_BLD_ID : dr_sel_o = SEL_BLD_ID;
            OP_BYPASS : dr_sel_o = SEL_BYPASS;
            OP_DTMCS  : begin
                dr_sel_o  = SEL_CHAIN;
                dmi_sel_o = 1'b1;
                ch_id_o   = `TAP_CH_ID_W'(1);
            end
            OP_DMI    : begin
                dr_sel_o  = SEL_CHAIN;
                dmi_sel_o = 1'b1;
                ch_id_o   = `TAP_CH_ID_W'(2);
            end
            // SCU uses chain id 0
            OP_SCU    : begin
                dr_sel_o  = SEL_CHAIN;
                scu_sel_o = 1'b1;
            end
            // Unknown opcodes fall back to BYPASS
            default   : dr_sel_o = SEL_BYPASS;
        endcase
    end

endmodule

/* design/tap_params.svh */
`ifndef TAP_PARAMS_SVH
`define TAP_PARAMS_SVH

// --------------------------------------------------
// Register widths
// --------------------------------------------------
`define TAP_IR_W         5
`define TAP_IDCODE_W     32
`define TAP_BLD_ID_W     32
`define TAP_BYPASS_W     1

// DMI/SCU chain identifier width
`define TAP_CH_ID_W      2

// Fixed value loaded by the BUILD ID register
`define TAP_BLD_ID_VALUE 32'h4A71_0C23

// --------------------------------------------------
// Instruction opcodes
// --------------------------------------------------
`define TAP_OP_IDCODE    5'h01
`define TAP_OP_BLD_ID    5'h04
`define TAP_OP_SCU       5'h09
`define TAP_OP_DTMCS     5'h10
`define TAP_OP_DMI       5'h11
`define TAP_OP_BYPASS    5'h1F

`endif

/* design/tap_state_pkg.sv */
package tap_state_pkg;

    // --------------------------------------------------
    // IEEE 1149.1 controller states
    // --------------------------------------------------
    typedef enum logic [3:0] {
        TAP_RESET      = 4'd0,
        TAP_IDLE       = 4'd1,
        // Data column
        TAP_DR_SELECT  = 4'd2,
        TAP_DR_CAPTURE = 4'd3,
        TAP_DR_SHIFT   = 4'd4,
        TAP_DR_EXIT1   = 4'd5,
        TAP_DR_PAUSE   = 4'd6,
        TAP_DR_EXIT2   = 4'd7,
        TAP_DR_UPDATE  = 4'd8,
        // Instruction column
        TAP_IR_SELECT  = 4'd9,
        TAP_IR_CAPTURE = 4'd10,
        TAP_IR_SHIFT   = 4'd11,
        TAP_IR_EXIT1   = 4'd12,
        TAP_IR_PAUSE   = 4'd13,
        TAP_IR_EXIT2   = 4'd14,
        TAP_IR_UPDATE  = 4'd15
    } tap_state_e;

    // --------------------------------------------------
    // Phase strobes to the datapath
    // --------------------------------------------------
    typedef struct packed {
        // Decoded from current state
        logic ir_capture;
        logic ir_shift;
        logic ir_update;
        // Registered from next state
        logic dr_capture;
        logic dr_shift;
    } tap_ctrl_t;

endpackage

/* design/tap_tdo_out.sv */
`timescale 1ns/10ps

module tap_tdo_out (
    input  logic                        tapc_tck,
    input  logic                        tapc_trst_n,
    input  logic                        sync_rst_n_i,
    input  tap_state_pkg::tap_ctrl_t    ctrl_i,
    input  tap_instr_pkg::tap_dr_sel_e  dr_sel_i,
    // Serial sources
    input  logic                        dr_tdo_i,
    input  logic                        chain_tdo_i,
    input  logic                        ir_lsb_i,
    // Pad side
    output logic                        tdo_o,
    output logic                        tdo_en_o
);

    import tap_instr_pkg::*;

    logic tdo_d;
    logic tdo_en_d;

    // --------------------------------------------------
    // Source select
    // --------------------------------------------------
    always_comb begin
        if (ctrl_i.dr_shift) begin
            tdo_d = (dr_sel_i == SEL_CHAIN) ? chain_tdo_i : dr_tdo_i;
        end else if (ctrl_i.ir_shift) begin
            tdo_d = ir_lsb_i;
        end else begin
            tdo_d = 1'b0;
        end
    end

    // Driver on only in shift states
    assign tdo_en_d = ctrl_i.dr_shift | ctrl_i.ir_shift;

    // TDO changes on falling TCK
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            tdo_o    <= 1'b0;
            tdo_en_o <= 1'b0;
        end else if (!sync_rst_n_i) begin
            tdo_o    <= 1'b0;
            tdo_en_o <= 1'b0;
        end else begin
            tdo_o    <= tdo_d;
            tdo_en_o <= tdo_en_d;
        end
    end

endmodule

/* design/tap_top.sv */
`timescale 1ns/10ps
`include "tap_params.svh"

module tap_top (
    // JTAG port
    input  logic                        tapc_tck,
    input  logic                        tapc_trst_n,
    input  logic                        tms_i,
    input  logic                        tdi_i,
    output logic                        tdo_o,
    output logic                        tdo_en_o,
    // Fuse value for IDCODE
    input  logic [`TAP_IDCODE_W-1:0]    idcode_i,
    // DMI/SCU scan chains
    input  logic                        chain_tdo_i,
    output tap_instr_pkg::tap_chain_t   chain_o
);

    import tap_state_pkg::*;
    import tap_instr_pkg::*;

    tap_ctrl_t               ctrl;
    logic                    dr_update;
    logic                    sync_rst_n;

    // Instruction decode
    tap_dr_sel_e             dr_sel;
    logic                    dmi_sel;
    logic                    scu_sel;
    logic [`TAP_CH_ID_W-1:0] ch_id;
    logic                    ir_lsb;

    logic                    dr_tdo;

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    tap_fsm_ctrl u_fsm_ctrl (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .tms_i        (tms_i),
        .ctrl_o       (ctrl),
        .dr_update_o  (dr_update),
        .sync_rst_n_o (sync_rst_n)
    );

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    tap_ir_reg u_ir_reg (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .sync_rst_n_i (sync_rst_n),
        .ctrl_i       (ctrl),
        .tdi_i        (tdi_i),
        .ir_lsb_o     (ir_lsb),
        .dr_sel_o     (dr_sel),
        .dmi_sel_o    (dmi_sel),
        .scu_sel_o    (scu_sel),
        .ch_id_o      (ch_id)
    );

    tap_dr_bank u_dr_bank (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .sync_rst_n_i (sync_rst_n),
        .ctrl_i       (ctrl),
        .dr_sel_i     (dr_sel),
        .tdi_i        (tdi_i),
        .idcode_i     (idcode_i),
        .dr_tdo_o     (dr_tdo)
    );

    tap_tdo_out u_tdo_out (
        .tapc_tck     (tapc_tck),
        .tapc_trst_n  (tapc_trst_n),
        .sync_rst_n_i (sync_rst_n),
        .ctrl_i       (ctrl),
        .dr_sel_i     (dr_sel),
        .dr_tdo_i     (dr_tdo),
        .chain_tdo_i  (chain_tdo_i),
        .ir_lsb_i     (ir_lsb),
        .tdo_o        (tdo_o),
        .tdo_en_o     (tdo_en_o)
    );

    // Chain strobes follow the DR phases, TDI passes straight through
    assign chain_o = '{
        dmi_sel : dmi_sel,
        scu_sel : scu_sel,
        ch_id   : ch_id,
        capture : ctrl.dr_capture,
        shift   : ctrl.dr_shift,
        update  : dr_update,
        tdi     : tdi_i
    };

endmodule

/* list.f */
+incdir+design
design/tap_state_pkg.sv
design/tap_instr_pkg.sv
design/tap_fsm_ctrl.sv
design/tap_ir_reg.sv
design/tap_dr_bank.sv
design/tap_tdo_out.sv
design/tap_top.sv
verif/tap_assertions.sv
verif/tap_tb.sv

/* verif/tap_assertions.sv */
`timescale 1ns/10ps

module tap_assertions (
    input logic                      tapc_tck,
    input logic                      tapc_trst_n,
    input logic                      tms_i,
    input logic                      tdi_i,
    input logic                      tdo_en_i,
    input tap_instr_pkg::tap_chain_t chain_i
);

    // Failed assertion count
    int fail_cnt = 0;

    // --------------------------------------------------
    // JTAG and chain port rules
    // --------------------------------------------------
    // Inputs must be driven once out of reset
    a_inputs_known: assert property (@(posedge tapc_tck) disable iff (!tapc_trst_n)
        !$isunknown({tms_i, tdi_i}))
        else begin
            fail_cnt++;
            $error("TMS or TDI unknown on rising TCK");
        end

    // At most one DR phase strobe at a time
    a_strobes_onehot: assert property (@(posedge tapc_tck) disable iff (!tapc_trst_n)
        $onehot0({chain_i.capture, chain_i.shift, chain_i.update}))
        else begin
            fail_cnt++;
            $error("Chain capture, shift and update overlap");
        end

    a_single_chain: assert property (@(posedge tapc_tck) disable iff (!tapc_trst_n)
        !(chain_i.dmi_sel && chain_i.scu_sel))
        else begin
            fail_cnt++;
            $error("DMI and SCU chains selected together");
        end

    // Enable from the capture-phase falling edge is still low
    a_no_tdo_after_capture: assert property (@(negedge tapc_tck) disable iff (!tapc_trst_n)
        chain_i.capture |=> !tdo_en_i)
        else begin
            fail_cnt++;
            $error("TDO enabled in the cycle after a capture strobe");
        end

endmodule

bind tap_top tap_assertions u_assertions (
    .tapc_tck    (tapc_tck),
    .tapc_trst_n (tapc_trst_n),
    .tms_i       (tms_i),
    .tdi_i       (tdi_i),
    .tdo_en_i    (tdo_en_o),
    .chain_i     (chain_o)
);

/* verif/tap_tb.sv */
`timescale 1ns/10ps
`include "tap_params.svh"

module tap_tb;

    import tap_instr_pkg::*;

    // Tests take about 350 TCK cycles, so this leaves a wide margin
    localparam int MAX_CYCLES = 3000;

    logic                     tapc_tck;
    logic                     tapc_trst_n;
    logic                     tms;
    logic                     tdi;
    logic [`TAP_IDCODE_W-1:0] idcode;
    logic                     chain_tdo = 1'b0;
    logic                     tdo;
    logic                     tdo_en;
    tap_chain_t               chain;

    integer seed;
    int     cycle_cnt = 0;
    // Chain strobe counts
    int     cap_cnt   = 0;
    int     shift_cnt = 0;
    int     upd_cnt   = 0;

    tap_top dut0 (
        .tapc_tck    (tapc_tck),
        .tapc_trst_n (tapc_trst_n),
        .tms_i       (tms),
        .tdi_i       (tdi),
        .tdo_o       (tdo),
        .tdo_en_o    (tdo_en),
        .idcode_i    (idcode),
        .chain_tdo_i (chain_tdo),
        .chain_o     (chain)
    );

    // 8 ns TCK
    always #4 tapc_tck = ~tapc_tck;

    // --------------------------------------------------
    // Watchdog, strobe counters and chain model
    // --------------------------------------------------
    always @(posedge tapc_tck) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            stop_run($sformatf("Run did not finish within %0d TCK cycles", MAX_CYCLES));
        end
        if (dut0.u_assertions.fail_cnt != 0) begin
            stop_run("A protocol assertion on the JTAG or chain port failed");
        end
    end

    // Strobes move on rising TCK, so count them on the falling edge
    always @(negedge tapc_tck) begin
        if (chain.capture) cap_cnt <= cap_cnt + 1;
        if (chain.shift) shift_cnt <= shift_cnt + 1;
        if (chain.update) upd_cnt <= upd_cnt + 1;
    end

    // Chain returns inverse of last TDI bit, 1 right after capture
    always @(posedge tapc_tck) begin
        if (chain.dmi_sel || chain.scu_sel) begin
            if (chain.capture) begin
                chain_tdo <= 1'b1;
            end else if (chain.shift) begin
                chain_tdo <= ~chain.tdi;
            end
        end
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Only the select fields, strobes are counted separately
    task automatic check_chain(input string name, input tap_chain_t exp,
                               input tap_chain_t act);
        if ({act.dmi_sel, act.scu_sel, act.ch_id} !== {exp.dmi_sel, exp.scu_sel, exp.ch_id}) begin
            stop_run($sformatf(
                "FAIL %s: expected dmi %b scu %b id %0d, actual dmi %b scu %b id %0d",
                name, exp.dmi_sel, exp.scu_sel, exp.ch_id,
                act.dmi_sel, act.scu_sel, act.ch_id));
        end
    endtask

    function automatic tap_chain_t chain_sel(input logic dmi, input logic scu,
                                             input logic [`TAP_CH_ID_W-1:0] id);
        tap_chain_t c;
        c         = '0;
        c.dmi_sel = dmi;
        c.scu_sel = scu;
        c.ch_id   = id;
        return c;
    endfunction

    // --------------------------------------------------
    // JTAG driver
    // --------------------------------------------------
    // Drive TMS/TDI now, TDO paired with that bit comes back at next rise
    task automatic tck_cycle(input logic t, input logic d, output logic q);
        tms <= t;
        tdi <= d;
        @(posedge tapc_tck);
        q = tdo;
    endtask

    // Run-Test/Idle to Exit1-IR
    task automatic shift_ir(input logic [`TAP_IR_W-1:0] op, output logic [`TAP_IR_W-1:0] cap);
        logic q;
        for (int i = 0; i < 4; i++) begin
            tck_cycle(i < 2, 1'b0, q);
        end
        for (int i = 0; i < `TAP_IR_W; i++) begin
            tck_cycle(i == `TAP_IR_W - 1, op[i], q);
            cap[i] = q;
        end
    endtask

    task automatic scan_ir(input logic [`TAP_IR_W-1:0] op, output logic [`TAP_IR_W-1:0] cap);
        logic q;
        shift_ir(op, cap);
        // Update-IR then back to idle
        tck_cycle(1'b1, 1'b0, q);
        tck_cycle(1'b0, 1'b0, q);
    endtask

    // Full data scan from idle to idle, TDO stored LSB first
    task automatic scan_dr(input int n, input logic [31:0] din, output logic [31:0] dout,
                           output int en_cnt);
        logic q;
        dout   = '0;
        en_cnt = 0;
        // Select, capture, shift entry
        for (int i = 0; i < 3; i++) begin
            tck_cycle(i == 0, 1'b0, q);
            en_cnt += tdo_en;
        end
        for (int i = 0; i < n; i++) begin
            tck_cycle(i == n - 1, din[i], q);
            dout[i] = q;
            en_cnt += tdo_en;
        end
        tck_cycle(1'b1, 1'b0, q);
        en_cnt += tdo_en;
        tck_cycle(1'b0, 1'b0, q);
        en_cnt += tdo_en;
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_idcode();
        logic [31:0] dout;
        int          en_cnt;
        logic        q;
        scan_dr(32, $random(seed), dout, en_cnt);
        check_word("idcode_default", idcode, dout);
        check_word("idcode_tdo_en_bits", 32, en_cnt);
        tck_cycle(1'b0, 1'b0, q);
        check_flag("idcode_tdo_en_idle", 1'b0, tdo_en);
    endtask

    task automatic test_ir_capture();
        logic [`TAP_IR_W-1:0] cap;
        logic                 q;
        shift_ir(`TAP_OP_DMI, cap);
        check_word("ir_capture_value", 32'h1, cap);
        // Selects stay put until the falling edge in Update-IR
        check_chain("ir_exit1_sel", chain_sel(1'b0, 1'b0, 0), chain);
        tck_cycle(1'b1, 1'b0, q);
        check_chain("ir_update_sel", chain_sel(1'b0, 1'b0, 0), chain);
        tck_cycle(1'b0, 1'b0, q);
        check_chain("ir_loaded_sel", chain_sel(1'b1, 1'b0, 2), chain);
        scan_ir(`TAP_OP_IDCODE, cap);
        check_word("ir_capture_again", 32'h1, cap);
    endtask

    // 12 bits through the 1-bit register come back one late
    task automatic test_bypass(input logic [`TAP_IR_W-1:0] op, input string name);
        logic [`TAP_IR_W-1:0] cap;
        logic [31:0]          din;
        logic [31:0]          dout;
        int                   en_cnt;
        din = $random(seed) & 32'hfff;
        scan_ir(op, cap);
        scan_dr(12, din, dout, en_cnt);
        check_word(name, (din << 1) & 32'hfff, dout);
    endtask

    task automatic test_bld_id();
        logic [`TAP_IR_W-1:0] cap;
        logic [31:0]          dout;
        int                   en_cnt;
        scan_ir(`TAP_OP_BLD_ID, cap);
        scan_dr(32, $random(seed), dout, en_cnt);
        check_word("bld_id_value", `TAP_BLD_ID_VALUE, dout);
    endtask

    task automatic test_chain(input logic [`TAP_IR_W-1:0] op, input tap_chain_t exp,
                              input string name);
        logic [`TAP_IR_W-1:0] cap;
        logic [31:0]          din;
        logic [31:0]          dout;
        int                   en_cnt;
        int                   cap0;
        int                   shift0;
        int                   upd0;
        scan_ir(op, cap);
        check_chain({name, "_sel"}, exp, chain);
        din    = $random(seed) & 32'hffff;
        cap0   = cap_cnt;
        shift0 = shift_cnt;
        upd0   = upd_cnt;
        scan_dr(16, din, dout, en_cnt);
        // Bit 0 from capture, then inverse of the previous TDI bit
        check_word({name, "_tdo"}, ((~din << 1) | 32'h1) & 32'hffff, dout);
        check_word({name, "_capture_pulses"}, 1, cap_cnt - cap0);
        check_word({name, "_shift_pulses"}, 16, shift_cnt - shift0);
        check_word({name, "_update_pulses"}, 1, upd_cnt - upd0);
    endtask

    task automatic test_reset_any_state();
        logic [`TAP_IR_W-1:0] cap;
        logic [31:0]          dout;
        int                   en_cnt;
        logic                 q;
        scan_ir(`TAP_OP_DMI, cap);
        // Into Shift-IR, BYPASS bits pending
        for (int i = 0; i < 4; i++) begin
            tck_cycle(i < 2, 1'b1, q);
        end
        repeat (`TAP_IR_W) tck_cycle(1'b0, 1'b1, q);
        // TDI high, so Update-IR on the way loads BYPASS
        repeat (5) tck_cycle(1'b1, 1'b1, q);
        // IR returns to IDCODE one falling edge after reaching idle
        tck_cycle(1'b0, 1'b0, q);
        tck_cycle(1'b0, 1'b0, q);
        check_chain("reset_sel", chain_sel(1'b0, 1'b0, 0), chain);
        scan_dr(32, $random(seed), dout, en_cnt);
        check_word("reset_idcode", idcode, dout);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        logic q;
        tapc_tck    = 1'b0;
        tapc_trst_n = 1'b0;
        tms         = 1'b1;
        tdi         = 1'b0;
        seed        = 22;
        idcode      = $random(seed);
        repeat (10) @(posedge tapc_tck);
        tapc_trst_n <= 1'b1;
        // Out of Test-Logic-Reset
        tck_cycle(1'b0, 1'b0, q);
        test_idcode();
        test_ir_capture();
        test_bypass(`TAP_OP_BYPASS, "bypass_opcode");
        test_bypass(5'h07, "bypass_unused_opcode");
        test_bld_id();
        test_chain(`TAP_OP_DTMCS, chain_sel(1'b1, 1'b0, 1), "chain_dtmcs");
        test_chain(`TAP_OP_DMI, chain_sel(1'b1, 1'b0, 2), "chain_dmi");
        test_chain(`TAP_OP_SCU, chain_sel(1'b0, 1'b1, 0), "chain_scu");
        test_reset_any_state();
        if (dut0.u_assertions.fail_cnt == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_run("A protocol assertion on the JTAG or chain port failed");
        end
    end

endmodule
